/* rtl/rv_bpred_macros.svh */
`ifndef RV_BPRED_MACROS_SVH
`define RV_BPRED_MACROS_SVH

// Width of the PC, the immediates and every predicted target
`define RV_XLEN 32

// Number of direct-mapped BTB entries
// Must be a power of two so the index is a plain PC bit slice
`define RV_BTB_ENTRIES 16

// Number of return addresses the RAS holds before it wraps
`define RV_RAS_DEPTH 4

`endif

/* rtl/rv_bpred_pkg.sv */
`default_nettype none

`include "rv_bpred_macros.svh"

package rv_bpred_pkg;

    // B-type field view, laid out from bit 31 down to bit 0
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_b_fmt_t;

    // J-type field view, used for JAL
    // The rd and opcode positions are common to all formats, so JALR reads them here too
    typedef struct packed {
        logic        imm20;
        logic [9:0]  imm10_1;
        logic        imm11;
        logic [7:0]  imm19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_j_fmt_t;

    // One fetched instruction word with its two decodings
    typedef union packed {
        rv_b_fmt_t b_fmt;
        rv_j_fmt_t j_fmt;
    } rv_instr_u;

    // PC source selected by the ID stage
    typedef enum logic [1:0] {
        PC_SEL_SEQUENTIAL = 2'b00,
        PC_SEL_PREDICTED  = 2'b01
    } pc_sel_e;

    // Control-flow class of the fetched word and its PC-relative offset
    typedef struct packed {
        logic                is_branch;
        logic                is_jal;
        logic                is_jalr;
        logic                is_call;
        logic                is_return;
        logic [`RV_XLEN-1:0] imm;
    } predecode_t;

    // BTB half of the IF-stage prediction
    typedef struct packed {
        logic                hit;
        logic                taken;
        logic [`RV_XLEN-1:0] tgt;
    } btb_lookup_t;

    // Everything predicted in IF, carried down to ID
    typedef struct packed {
        logic                btb_hit;
        logic                btb_taken;
        logic [`RV_XLEN-1:0] btb_tgt;
        logic                ras_valid;
        logic [`RV_XLEN-1:0] ras_tgt;
    } if_pred_t;

    // One resolved branch or JAL reported by execute
    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic                taken;
        logic [`RV_XLEN-1:0] target;
    } resolve_t;

    // Contents of the IF-to-ID pipeline register
    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        predecode_t          dec;
        if_pred_t            pred;
    } id_stage_t;

endpackage

`default_nettype wire

/* rtl/rv_instr_predecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_bpred_macros.svh"

module rv_instr_predecode import rv_bpred_pkg::*; (
    input  rv_instr_u  instr,
    output predecode_t dec
);

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic       rd_link;
    logic       rs1_link;

    // Opcode, rd and rs1 sit at the same bits in every format
    assign opcode = instr.j_fmt.opcode;
    assign rd     = instr.j_fmt.rd;
    assign rs1    = instr.b_fmt.rs1;

    // Standard link registers are ra (x1) and t0 (x5)
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    always_comb begin
        dec           = '0;
        dec.is_branch = (opcode == OPC_BRANCH);
        dec.is_jal    = (opcode == OPC_JAL);
        dec.is_jalr   = (opcode == OPC_JALR);

        // A call links through x1 or x5, whichever jump form it uses
        dec.is_call   = (dec.is_jal || dec.is_jalr) && rd_link;

        // A return jumps through a link register and discards the link
        dec.is_return = dec.is_jalr && (rd == 5'd0) && rs1_link;

        // Only the PC-relative forms carry an offset the predictor can use
        if (dec.is_branch) begin
            dec.imm = {{(`RV_XLEN-12){instr.b_fmt.imm12}}, instr.b_fmt.imm11,
                       instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
        end else if (dec.is_jal) begin
            dec.imm = {{(`RV_XLEN-20){instr.j_fmt.imm20}}, instr.j_fmt.imm19_12,
                       instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_btb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_bpred_macros.svh"

module rv_btb import rv_bpred_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`RV_XLEN-1:0] lookup_pc,
    output btb_lookup_t         lookup,
    input  resolve_t            resolve
);

    localparam int IDX_W = $clog2(`RV_BTB_ENTRIES);
    localparam int TAG_W = `RV_XLEN - IDX_W - 2;

    // Only the valid bits are control state, the rest is payload
    logic [`RV_BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]           tag_q [`RV_BTB_ENTRIES];
    logic [`RV_XLEN-1:0]        tgt_q [`RV_BTB_ENTRIES];
    logic [1:0]                 ctr_q [`RV_BTB_ENTRIES];

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] rs_idx;
    logic [TAG_W-1:0] rs_tag;
    logic             rs_hit;
    logic [1:0]       ctr_next;

    // Instructions are word aligned, so bits 1:0 take no part in the lookup
    assign lk_idx = lookup_pc[IDX_W+1:2];
    assign lk_tag = lookup_pc[`RV_XLEN-1:IDX_W+2];

    assign lookup.hit   = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign lookup.taken = ctr_q[lk_idx][1];
    assign lookup.tgt   = tgt_q[lk_idx];

    assign rs_idx = resolve.pc[IDX_W+1:2];
    assign rs_tag = resolve.pc[`RV_XLEN-1:IDX_W+2];
    assign rs_hit = valid_q[rs_idx] && (tag_q[rs_idx] == rs_tag);

    // Saturating 2-bit counter step toward the resolved outcome
    always_comb begin
        ctr_next = ctr_q[rs_idx];
        if (resolve.taken && ctr_q[rs_idx] != 2'b11) begin
            ctr_next = ctr_q[rs_idx] + 2'b01;
        end else if (!resolve.taken && ctr_q[rs_idx] != 2'b00) begin
            ctr_next = ctr_q[rs_idx] - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (resolve.valid) begin
            valid_q[rs_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resolve.valid) begin
            if (!rs_hit) begin
                // Allocation replaces whatever aliased into this slot
                // The counter starts weak so one wrong outcome flips it
                tag_q[rs_idx] <= rs_tag;
                tgt_q[rs_idx] <= resolve.target;
                ctr_q[rs_idx] <= resolve.taken ? 2'b10 : 2'b01;
            end else begin
                ctr_q[rs_idx] <= ctr_next;
                // A not-taken outcome says nothing about the target
                if (resolve.taken) begin
                    tgt_q[rs_idx] <= resolve.target;
                end
            end
        end
    end

    // Execute only reports word-aligned instructions, the index assumes it
    a_resolve_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        resolve.valid |-> (resolve.pc[1:0] == 2'b00)
    ) else $error("BTB resolve with misaligned pc");

endmodule

`default_nettype wire

/* rtl/rv_ras.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_bpred_macros.svh"

module rv_ras (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  logic                pop,
    input  logic [`RV_XLEN-1:0] push_addr,
    output logic [`RV_XLEN-1:0] top,
    output logic                not_empty
);

    localparam int PTR_W = $clog2(`RV_RAS_DEPTH);
    localparam int CNT_W = $clog2(`RV_RAS_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(`RV_RAS_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`RV_RAS_DEPTH);

    logic [`RV_XLEN-1:0] stack_q [`RV_RAS_DEPTH];
    logic [PTR_W-1:0]    ptr_q;
    logic [CNT_W-1:0]    cnt_q;
    logic [PTR_W-1:0]    ptr_inc;
    logic [PTR_W-1:0]    ptr_dec;

    // Pointer arithmetic wraps explicitly so any depth works
    assign ptr_inc = (ptr_q == LAST_IDX) ? '0 : ptr_q + 1'b1;
    assign ptr_dec = (ptr_q == '0) ? LAST_IDX : ptr_q - 1'b1;

    // ptr_q always addresses the newest entry
    assign top       = stack_q[ptr_q];
    assign not_empty = (cnt_q != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q <= '0;
            cnt_q <= '0;
        end else if (push && !pop) begin
            ptr_q <= ptr_inc;
            // When full the count holds and the oldest slot gets overwritten
            if (cnt_q != FULL_CNT) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (pop && !push) begin
            ptr_q <= ptr_dec;
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push && pop) begin
            // Combined pop and push just swaps the top entry
            stack_q[ptr_q] <= push_addr;
        end else if (push) begin
            stack_q[ptr_inc] <= push_addr;
        end
    end

    // The control must not pop a stack that holds nothing
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pop && !push) |-> not_empty
    ) else $error("RAS pop while empty");

endmodule

`default_nettype wire

/* rtl/rv_bpred_id.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_bpred_macros.svh"

module rv_bpred_id import rv_bpred_pkg::*; (
    input  id_stage_t           id,
    output pc_sel_e             pc_sel_id,
    output logic [`RV_XLEN-1:0] pred_tgt,
    output logic                pred_taken_id,
    output logic                bpred_taken_id
);

    logic                predictable;
    logic                static_taken;
    logic                ras_pred;
    logic                btb_pred;
    logic [`RV_XLEN-1:0] static_tgt;
    logic                static_aligned;

    // Only PC-relative control flow has a target ID can compute
    assign predictable = id.dec.is_branch || id.dec.is_jal;

    // Backward branches are loop closers, so predict them taken along with JAL
    assign static_taken = (id.dec.is_branch && id.dec.imm[`RV_XLEN-1]) || id.dec.is_jal;

    // IF already redirected on a RAS hit for a return
    assign ras_pred = id.pred.ras_valid && id.dec.is_return;

    // IF may have redirected on a BTB hit, and either way the BTB owns this one
    assign btb_pred = id.pred.btb_hit && predictable;

    assign static_tgt     = id.pc + id.dec.imm;
    assign static_aligned = (static_tgt[1:0] == 2'b00);

    always_comb begin
        pred_taken_id = 1'b0;
        pred_tgt      = '0;
        // A second redirect here would restart fetch from the wrong PC
        // Misaligned targets are left for execute to trap on
        if (id.valid && predictable && !ras_pred && !btb_pred && static_aligned) begin
            pred_taken_id = static_taken;
            pred_tgt      = static_tgt;
        end
    end

    // Overall direction, with RAS over BTB over static
    always_comb begin
        if (!id.valid) begin
            bpred_taken_id = 1'b0;
        end else if (ras_pred) begin
            bpred_taken_id = 1'b1;
        end else if (btb_pred) begin
            bpred_taken_id = id.pred.btb_taken;
        end else begin
            bpred_taken_id = pred_taken_id;
        end
    end

    assign pc_sel_id = pred_taken_id ? PC_SEL_PREDICTED : PC_SEL_SEQUENTIAL;

endmodule

`default_nettype wire

/* rtl/rv_bpred_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_bpred_macros.svh"

module rv_bpred_ctrl import rv_bpred_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_valid,
    input  logic [`RV_XLEN-1:0] pc_if,
    input  predecode_t          dec,
    input  if_pred_t            if_pred,
    input  logic                flush,
    output id_stage_t           id,
    output logic                if_redirect,
    output logic [`RV_XLEN-1:0] if_tgt,
    output logic                ras_push,
    output logic                ras_pop,
    output logic [`RV_XLEN-1:0] ras_push_addr
);

    logic                ras_redirect;
    logic                btb_redirect;
    logic                id_valid_q;
    logic [`RV_XLEN-1:0] id_pc_q;
    predecode_t          id_dec_q;
    if_pred_t            id_pred_q;

    // A return is predicted from the RAS top whenever the stack holds something
    assign ras_redirect = fetch_valid && dec.is_return && if_pred.ras_valid;

    // Branches and JAL follow the BTB only if the counter leans taken
    assign btb_redirect = fetch_valid && if_pred.btb_hit && if_pred.btb_taken &&
                          (dec.is_branch || dec.is_jal);

    assign if_redirect = ras_redirect || btb_redirect;

    always_comb begin
        if (ras_redirect) begin
            if_tgt = if_pred.ras_tgt;
        end else if (btb_redirect) begin
            if_tgt = if_pred.btb_tgt;
        end else begin
            if_tgt = '0;
        end
    end

    // A flush at the fetch edge kills the instruction before it reaches ID
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid_q <= 1'b0;
        end else begin
            id_valid_q <= fetch_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            id_pc_q   <= pc_if;
            id_dec_q  <= dec;
            id_pred_q <= if_pred;
        end
    end

    assign id = '{valid: id_valid_q, pc: id_pc_q, dec: id_dec_q, pred: id_pred_q};

    // The RAS is updated from ID, after the instruction is known to be live
    // The pop check uses the live stack state, not the copy taken in IF
    assign ras_push      = id_valid_q && id_dec_q.is_call;
    assign ras_pop       = id_valid_q && id_dec_q.is_return && if_pred.ras_valid;
    assign ras_push_addr = id_pc_q + `RV_XLEN'(4);

endmodule

`default_nettype wire

/* rtl/rv_bpred_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_bpred_macros.svh"

module rv_bpred_top import rv_bpred_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_valid,
    input  logic [`RV_XLEN-1:0] pc_if,
    input  rv_instr_u           instr_if,
    input  logic                flush,
    input  resolve_t            resolve,
    output logic                if_redirect,
    output logic [`RV_XLEN-1:0] if_tgt,
    output pc_sel_e             pc_sel_id,
    output logic [`RV_XLEN-1:0] pred_tgt,
    output logic                pred_taken_id,
    output logic                bpred_taken_id
);

    predecode_t          dec_if;
    btb_lookup_t         btb_lookup;
    if_pred_t            if_pred;
    id_stage_t           id;
    logic                ras_push;
    logic                ras_pop;
    logic [`RV_XLEN-1:0] ras_push_addr;
    logic [`RV_XLEN-1:0] ras_top;
    logic                ras_not_empty;

    rv_instr_predecode u_predecode (
        .instr (instr_if),
        .dec   (dec_if)
    );

    rv_btb u_btb (
        .clk       (clk),
        .rst_n     (rst_n),
        .lookup_pc (pc_if),
        .lookup    (btb_lookup),
        .resolve   (resolve)
    );

    rv_ras u_ras (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (ras_push),
        .pop       (ras_pop),
        .push_addr (ras_push_addr),
        .top       (ras_top),
        .not_empty (ras_not_empty)
    );

    // Both IF predictors merged into one bundle for the control
    assign if_pred = '{btb_hit: btb_lookup.hit, btb_taken: btb_lookup.taken,
                       btb_tgt: btb_lookup.tgt, ras_valid: ras_not_empty,
                       ras_tgt: ras_top};

    rv_bpred_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),
        .pc_if         (pc_if),
        .dec           (dec_if),
        .if_pred       (if_pred),
        .flush         (flush),
        .id            (id),
        .if_redirect   (if_redirect),
        .if_tgt        (if_tgt),
        .ras_push      (ras_push),
        .ras_pop       (ras_pop),
        .ras_push_addr (ras_push_addr)
    );

    rv_bpred_id u_id (
        .id             (id),
        .pc_sel_id      (pc_sel_id),
        .pred_tgt       (pred_tgt),
        .pred_taken_id  (pred_taken_id),
        .bpred_taken_id (bpred_taken_id)
    );

endmodule

`default_nettype wire

/* verification/rv_bpred_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_bpred_macros.svh"

module rv_bpred_tb import rv_bpred_pkg::*; ();

    // Each stimulus line holds this many hex words
    localparam int FIELDS     = 9;
    localparam int MAX_VECS   = 64;
    localparam int RST_CYCLES = 10;
    localparam int IDLE_LIMIT = 8;

    logic                clk;
    logic                rst_n;
    logic                fetch_valid;
    logic [`RV_XLEN-1:0] pc_if;
    rv_instr_u           instr_if;
    logic                flush;
    resolve_t            resolve;
    logic                if_redirect;
    logic [`RV_XLEN-1:0] if_tgt;
    pc_sel_e             pc_sel_id;
    logic [`RV_XLEN-1:0] pred_tgt;
    logic                pred_taken_id;
    logic                bpred_taken_id;

    logic [31:0] stim [0:FIELDS*MAX_VECS-1];
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    logic [7:0]  cur_test;

    rv_bpred_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_valid    (fetch_valid),
        .pc_if          (pc_if),
        .instr_if       (instr_if),
        .flush          (flush),
        .resolve        (resolve),
        .if_redirect    (if_redirect),
        .if_tgt         (if_tgt),
        .pc_sel_id      (pc_sel_id),
        .pred_tgt       (pred_tgt),
        .pred_taken_id  (pred_taken_id),
        .bpred_taken_id (bpred_taken_id)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // No fetch, no flush and no resolve report
    task automatic drive_idle();
        fetch_valid = 1'b0;
        pc_if       = '0;
        instr_if    = '0;
        flush       = 1'b0;
        resolve     = '0;
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    // True when every IF and ID output is in its inactive state
    function automatic logic outputs_idle();
        return !if_redirect && (if_tgt == '0) && (pc_sel_id == PC_SEL_SEQUENTIAL) &&
               (pred_tgt == '0) && !pred_taken_id && !bpred_taken_id;
    endfunction

    // Holds reset for the full count, then waits for the outputs to settle
    task automatic apply_reset(input logic [`RV_XLEN-1:0] hold_pc,
                               input logic [31:0] hold_instr);
        int waited;
        @(negedge clk);
        rst_n = 1'b0;
        drive_idle();
        // The upcoming fetch is already on the bus, and reset alone keeps it out of ID
        fetch_valid = 1'b1;
        pc_if       = hold_pc;
        instr_if    = hold_instr;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        drive_idle();
        #2;
        waited = 0;
        while (!outputs_idle() && waited < IDLE_LIMIT) begin
            @(negedge clk);
            #2;
            waited++;
        end
        if (!outputs_idle()) begin
            $display("Timeout: DUT outputs still active %0d cycles after reset", IDLE_LIMIT);
            errors++;
            test_errors++;
        end else if (waited != 0) begin
            report_mismatch($sformatf("outputs active for %0d cycles after reset", waited));
        end
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d: ok", cur_test);
        end else begin
            $display("test %0d: %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        int          v;
        int          base;
        int          gap;
        logic [31:0] ctl;
        logic [31:0] flags;
        pc_sel_e     exp_sel;

        void'($urandom(48444));
        rst_n        = 1'b0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        drive_idle();
        $readmemh("verification/rv_bpred_stimulus.txt", stim);
        apply_reset(stim[2], stim[3]);
        cur_test = stim[0][7:0];

        for (v = 0; v < MAX_VECS; v++) begin
            base = v * FIELDS;
            if ($isunknown(stim[base])) begin
                $display("Stimulus file is missing or lacks its end marker");
                errors++;
                break;
            end
            // Test id ff marks the end of the vectors
            if (stim[base] == 32'hff) begin
                break;
            end
            if (stim[base][7:0] != cur_test) begin
                close_test();
                cur_test = stim[base][7:0];
            end
            ctl   = stim[base+1];
            flags = stim[base+6];
            if (ctl[4]) begin
                apply_reset(stim[base+FIELDS+2], stim[base+FIELDS+3]);
                continue;
            end

            // Fetch cycle, where the IF redirect is combinational
            @(negedge clk);
            fetch_valid    = ctl[0];
            flush          = ctl[1];
            pc_if          = stim[base+2];
            instr_if       = stim[base+3];
            resolve.valid  = ctl[2];
            resolve.taken  = ctl[3];
            resolve.pc     = stim[base+4];
            resolve.target = stim[base+5];
            #2;
            if (if_redirect !== flags[0]) begin
                report_mismatch($sformatf("vector %0d if_redirect %0b expected %0b",
                                          v, if_redirect, flags[0]));
            end
            if (if_tgt !== stim[base+7]) begin
                report_mismatch($sformatf("vector %0d if_tgt %h expected %h",
                                          v, if_tgt, stim[base+7]));
            end

            // The same instruction one cycle later in ID
            @(negedge clk);
            drive_idle();
            #2;
            exp_sel = flags[1] ? PC_SEL_PREDICTED : PC_SEL_SEQUENTIAL;
            if (pc_sel_id !== exp_sel) begin
                report_mismatch($sformatf("vector %0d pc_sel_id %0d expected %0d",
                                          v, pc_sel_id, exp_sel));
            end
            if (pred_taken_id !== flags[2]) begin
                report_mismatch($sformatf("vector %0d pred_taken_id %0b expected %0b",
                                          v, pred_taken_id, flags[2]));
            end
            if (bpred_taken_id !== flags[3]) begin
                report_mismatch($sformatf("vector %0d bpred_taken_id %0b expected %0b",
                                          v, bpred_taken_id, flags[3]));
            end
            if (pred_tgt !== stim[base+8]) begin
                report_mismatch($sformatf("vector %0d pred_tgt %h expected %h",
                                          v, pred_tgt, stim[base+8]));
            end

            // A few empty fetch cycles between vectors
            gap = $urandom_range(2, 0);
            repeat (gap) @(negedge clk);
        end

        close_test();
        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/rv_bpred_stimulus.txt */
// tid ctl pc instr res_pc res_tgt exp_flags exp_if_tgt exp_pred_tgt
// ctl: 1 fetch, 2 flush, 4 resolve, 8 resolve taken, 10 reset
// exp_flags: 1 if_redirect, 2 pc_sel predicted, 4 pred_taken_id, 8 bpred_taken_id
01 01 00000100 fe0008e3 00000000 00000000 e 00000000 000000f0
01 01 00000200 00000863 00000000 00000000 0 00000000 00000210
01 01 00000300 0200006f 00000000 00000000 e 00000000 00000320
01 01 00000102 fe0008e3 00000000 00000000 0 00000000 00000000
02 0c 00000000 00000000 00000400 00000480 0 00000000 00000000
02 01 00000400 00000863 00000000 00000000 9 00000480 00000000
03 04 00000000 00000000 00000400 00000480 0 00000000 00000000
03 04 00000000 00000000 00000400 00000480 0 00000000 00000000
03 01 00000400 00000863 00000000 00000000 0 00000000 00000000
03 0c 00000000 00000000 00000400 000004c0 0 00000000 00000000
03 01 00000400 00000863 00000000 00000000 0 00000000 00000000
03 0c 00000000 00000000 00000400 000004c0 0 00000000 00000000
03 01 00000400 00000863 00000000 00000000 9 000004c0 00000000
04 01 00000500 040000ef 00000000 00000000 e 00000000 00000540
04 01 00000600 00008067 00000000 00000000 9 00000504 00000000
04 01 00000608 00008067 00000000 00000000 0 00000000 00000000
05 01 00000500 040000ef 00000000 00000000 e 00000000 00000540
05 03 00000100 fe0008e3 00000000 00000000 0 00000000 00000000
05 10 00000000 00000000 00000000 00000000 0 00000000 00000000
05 01 00000400 00000863 00000000 00000000 0 00000000 00000410
05 01 00000600 00008067 00000000 00000000 0 00000000 00000000
ff 00 00000000 00000000 00000000 00000000 0 00000000 00000000

/* rv_bpred.f */
+incdir+rtl
rtl/rv_bpred_pkg.sv
rtl/rv_instr_predecode.sv
rtl/rv_btb.sv
rtl/rv_ras.sv
rtl/rv_bpred_id.sv
rtl/rv_bpred_ctrl.sv
rtl/rv_bpred_top.sv
verification/rv_bpred_tb.sv

/* run_rv_bpred.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rv_bpred_tb -f rv_bpred.f -o rv_bpred_sim \
    && ./obj_dir/rv_bpred_sim | tee /dev/stderr | grep -q "TEST PASSED" \
    && exit 0 || exit 1
